// File: common/tomasulo_pkg.sv
`default_nettype none

// shared types and constants for the rename and commit core
package tomasulo_pkg;

    // architectural data word
    typedef logic [31:0] word_t;

    // index into the 32 architectural registers
    typedef logic [4:0] reg_idx_t;

    // reorder buffer tag, where zero means the register has no pending producer
    // and tags 1 and up name buffer slots 0 and up
    typedef logic [4:0] rob_tag_t;

    // major opcode field of an RV32I instruction word
    typedef logic [6:0] opcode_t;

    // stores and branches are the only base opcodes that leave rd alone
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // marks a register whose value is already architectural
    localparam rob_tag_t NO_TAG = 5'd0;

endpackage : tomasulo_pkg

`default_nettype wire

// File: register_status/register_status_file.sv
`timescale 1ns/1ps
`default_nettype none

// architectural register file with one pending producer tag per register
module register_status_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    // rename side, from dispatch
    input  logic                  load_tag,
    input  tomasulo_pkg::reg_idx_t tag_rd,
    input  tomasulo_pkg::rob_tag_t rd_tag,

    // commit side, from the reorder buffer
    input  logic                  load_reg,
    input  tomasulo_pkg::reg_idx_t commit_rd,
    input  tomasulo_pkg::word_t    commit_value,
    input  tomasulo_pkg::rob_tag_t commit_tag,

    // operand read ports
    input  tomasulo_pkg::reg_idx_t rs1,
    input  tomasulo_pkg::reg_idx_t rs2,
    output tomasulo_pkg::word_t    vj,
    output tomasulo_pkg::word_t    vk,
    output tomasulo_pkg::rob_tag_t qj,
    output tomasulo_pkg::rob_tag_t qk
);

    // committed register values
    tomasulo_pkg::word_t    values [32];

    // producer tag per register, NO_TAG once the value is architectural
    tomasulo_pkg::rob_tag_t tags [32];

    // reads are combinational and see the state from before the edge
    // x0 is hardwired to zero and never has a producer
    assign vj = (rs1 == 5'd0) ? 32'h0000_0000 : values[rs1];
    assign vk = (rs2 == 5'd0) ? 32'h0000_0000 : values[rs2];
    assign qj = (rs1 == 5'd0) ? tomasulo_pkg::NO_TAG : tags[rs1];
    assign qk = (rs2 == 5'd0) ? tomasulo_pkg::NO_TAG : tags[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                values[i] <= 32'h0000_0000;
                tags[i]   <= tomasulo_pkg::NO_TAG;
            end
        end else if (flush) begin
            // every in-flight producer is discarded, so nothing is pending anymore
            // committed values are kept as they are
            for (int i = 0; i < 32; i++) begin
                tags[i] <= tomasulo_pkg::NO_TAG;
            end
        end else begin
            // retiring entry writes its value; writes to x0 are dropped
            if (load_reg && commit_rd != 5'd0) begin
                values[commit_rd] <= commit_value;

                // only the newest producer may clear the tag, otherwise an
                // older write would hide a younger one that is still in flight
                if (tags[commit_rd] == commit_tag) begin
                    tags[commit_rd] <= tomasulo_pkg::NO_TAG;
                end
            end

            // a rename in the same cycle is issued after the committing entry,
            // so its tag must survive; placing it last lets it win the clear above
            if (load_tag && tag_rd != 5'd0) begin
                tags[tag_rd] <= rd_tag;
            end
        end
    end

endmodule : register_status_file

`default_nettype wire

// File: reorder_buffer/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// circular in-order commit queue
// allocates tags at the tail, takes completions anywhere, retires the head
module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    // allocation from dispatch
    input  logic                  alloc,
    input  tomasulo_pkg::reg_idx_t alloc_rd,
    output tomasulo_pkg::rob_tag_t alloc_tag,
    output logic                  rob_full,

    // completion broadcast from the functional units
    input  logic                  cdb_valid,
    input  tomasulo_pkg::rob_tag_t cdb_tag,
    input  tomasulo_pkg::word_t    cdb_value,

    // head entry on its way to the register file
    output logic                  commit_valid,
    output tomasulo_pkg::reg_idx_t commit_rd,
    output tomasulo_pkg::word_t    commit_value,
    output tomasulo_pkg::rob_tag_t commit_tag
);

    localparam int PTR_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(ROB_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(ROB_DEPTH);
    localparam tomasulo_pkg::rob_tag_t MAX_TAG = tomasulo_pkg::rob_tag_t'(ROB_DEPTH);

    // per-slot control state
    logic                   busy  [ROB_DEPTH];
    logic                   ready [ROB_DEPTH];

    // per-slot payload
    tomasulo_pkg::reg_idx_t rd    [ROB_DEPTH];
    tomasulo_pkg::word_t    value [ROB_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic             do_alloc;
    logic             do_commit;
    logic             cdb_hit;
    logic [PTR_W-1:0] cdb_slot;

    // tag is slot number plus one so that zero stays free for "no producer"
    assign alloc_tag  = tomasulo_pkg::rob_tag_t'(tail) + 5'd1;
    assign commit_tag = tomasulo_pkg::rob_tag_t'(head) + 5'd1;
    assign rob_full   = (count == FULL_CNT);

    // dispatch already holds alloc low when full; checked again so the
    // pointers can never overrun the head
    assign do_alloc  = alloc && !rob_full;

    // head retires as soon as its result is in, unless a flush throws it away
    assign commit_valid = busy[head] && ready[head] && !flush;
    assign do_commit    = commit_valid;
    assign commit_rd    = rd[head];
    assign commit_value = value[head];

    // completions for tags that are out of range or not in flight are ignored
    assign cdb_slot = PTR_W'(cdb_tag - 5'd1);
    assign cdb_hit  = cdb_valid && (cdb_tag != tomasulo_pkg::NO_TAG)
                      && (cdb_tag <= MAX_TAG) && busy[cdb_slot];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                busy[i]  <= 1'b0;
                ready[i] <= 1'b0;
            end
        end else begin
            // result lands in its slot and the entry becomes committable
            if (cdb_hit) begin
                ready[cdb_slot] <= 1'b1;
                value[cdb_slot] <= cdb_value;
            end

            // the tail slot is free here, so it never collides with the head
            if (do_alloc) begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                rd[tail]    <= alloc_rd;
                tail        <= (tail == LAST_SLOT) ? '0 : tail + 1'b1;
            end

            if (do_commit) begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= (head == LAST_SLOT) ? '0 : head + 1'b1;
            end

            // occupancy only moves when exactly one side is active
            case ({do_alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : reorder_buffer

`default_nettype wire

// File: design/dispatch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// decodes register fields of an RV32I word and decides whether it may issue
module dispatch_unit (
    input  logic                  issue,
    input  tomasulo_pkg::word_t    instr,
    input  logic                  rob_full,
    output logic                  alloc,
    output tomasulo_pkg::reg_idx_t rs1,
    output tomasulo_pkg::reg_idx_t rs2,
    output tomasulo_pkg::reg_idx_t rd,
    output logic                  has_rd,
    output logic                  load_tag
);

    tomasulo_pkg::opcode_t  opcode;
    tomasulo_pkg::reg_idx_t rd_field;

    // field positions are shared by every RV32I format that has them
    assign opcode   = instr[6:0];
    assign rd_field = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];

    // stores and branches reuse bits 11:7 for immediate data
    assign has_rd = (opcode != tomasulo_pkg::OPC_STORE)
                    && (opcode != tomasulo_pkg::OPC_BRANCH);

    // non-writing entries still go through the buffer, but retire to x0
    assign rd = has_rd ? rd_field : 5'd0;

    // a strobe while the buffer is full is lost, there is no stall path
    assign alloc = issue && !rob_full;

    // x0 never gets a producer tag
    assign load_tag = alloc && has_rd && (rd != 5'd0);

endmodule : dispatch_unit

`default_nettype wire

// File: design/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

// rename and commit core: dispatch, register status file and reorder buffer
module rename_core #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    // issue
    input  logic                  issue,
    input  tomasulo_pkg::word_t    instr,

    // completion broadcast
    input  logic                  cdb_valid,
    input  tomasulo_pkg::rob_tag_t cdb_tag,
    input  tomasulo_pkg::word_t    cdb_value,

    // rename results for the instruction on instr
    output tomasulo_pkg::rob_tag_t issue_tag,
    output tomasulo_pkg::word_t    vj,
    output tomasulo_pkg::word_t    vk,
    output tomasulo_pkg::rob_tag_t qj,
    output tomasulo_pkg::rob_tag_t qk,
    output logic                  rob_full,

    // retirement
    output logic                  commit_valid,
    output tomasulo_pkg::reg_idx_t commit_rd,
    output tomasulo_pkg::word_t    commit_value
);

    logic                   alloc;
    logic                   load_tag;
    tomasulo_pkg::reg_idx_t rs1;
    tomasulo_pkg::reg_idx_t rs2;
    tomasulo_pkg::reg_idx_t rd;
    tomasulo_pkg::rob_tag_t commit_tag;

    // has_rd is already folded into load_tag and the masked rd
    dispatch_unit u_dispatch (
        .issue    (issue),
        .instr    (instr),
        .rob_full (rob_full),
        .alloc    (alloc),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .has_rd   (),
        .load_tag (load_tag)
    );

    // the tail tag is both the issue tag and the new producer for rd
    register_status_file u_regs (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .load_tag     (load_tag),
        .tag_rd       (rd),
        .rd_tag       (issue_tag),
        .load_reg     (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag),
        .rs1          (rs1),
        .rs2          (rs2),
        .vj           (vj),
        .vk           (vk),
        .qj           (qj),
        .qk           (qk)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (alloc),
        .alloc_rd     (rd),
        .alloc_tag    (issue_tag),
        .rob_full     (rob_full),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .commit_tag   (commit_tag)
    );

endmodule : rename_core

`default_nettype wire

// File: verification/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the rename and commit core
// a small reference model tracks committed values, pending tags and the commit order
module rename_core_tb;

    localparam int ROB_DEPTH = 8;
    localparam tomasulo_pkg::rob_tag_t LAST_TAG = 5'd8;

    // RV32I opcodes used to build instruction words
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic                   issue;
    tomasulo_pkg::word_t    instr;
    logic                   cdb_valid;
    tomasulo_pkg::rob_tag_t cdb_tag;
    tomasulo_pkg::word_t    cdb_value;
    tomasulo_pkg::rob_tag_t issue_tag;
    tomasulo_pkg::word_t    vj;
    tomasulo_pkg::word_t    vk;
    tomasulo_pkg::rob_tag_t qj;
    tomasulo_pkg::rob_tag_t qk;
    logic                   rob_full;
    logic                   commit_valid;
    tomasulo_pkg::reg_idx_t commit_rd;
    tomasulo_pkg::word_t    commit_value;

    // reference model: architectural state, completed results and in-flight entries
    tomasulo_pkg::word_t    ref_val [32];
    tomasulo_pkg::rob_tag_t ref_tag [32];
    tomasulo_pkg::word_t    done_val [32];
    logic                   done [32];
    tomasulo_pkg::rob_tag_t pend_tag [$];
    tomasulo_pkg::reg_idx_t pend_rd [$];
    tomasulo_pkg::rob_tag_t next_tag;

    string test_name;
    int    test_errors;
    int    tests_run;
    int    tests_failed;

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) uut (
        .clk(clk), .rst(rst), .flush(flush), .issue(issue), .instr(instr),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
        .issue_tag(issue_tag), .vj(vj), .vk(vk), .qj(qj), .qk(qk), .rob_full(rob_full),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_word(input string what, input tomasulo_pkg::word_t exp,
                              input tomasulo_pkg::word_t act);
        if (exp !== act) begin
            $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_tag(input string what, input tomasulo_pkg::rob_tag_t exp,
                             input tomasulo_pkg::rob_tag_t act);
        if (exp !== act) begin
            $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_idx(input string what, input tomasulo_pkg::reg_idx_t exp,
                             input tomasulo_pkg::reg_idx_t act);
        if (exp !== act) begin
            $display("Fail %s: %s expected x%0d actual x%0d", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
    endtask

    function automatic tomasulo_pkg::word_t encode(input logic [6:0] op,
            input tomasulo_pkg::reg_idx_t d, input tomasulo_pkg::reg_idx_t s1,
            input tomasulo_pkg::reg_idx_t s2);
        // for stores and branches d lands in the low immediate bits
        return {7'd0, s2, s1, 3'd0, d, op};
    endfunction

    // every stimulus task starts and ends 1 ns after a rising edge
    task automatic issue_op(input tomasulo_pkg::word_t word,
                            output tomasulo_pkg::rob_tag_t tag);
        tomasulo_pkg::reg_idx_t d;
        tomasulo_pkg::reg_idx_t s1;
        tomasulo_pkg::reg_idx_t s2;
        logic                   writes;
        logic                   full;
        d      = word[11:7];
        s1     = word[19:15];
        s2     = word[24:20];
        writes = (word[6:0] != OP_STORE) && (word[6:0] != OP_BRANCH);
        full   = (pend_tag.size() == ROB_DEPTH);
        tag    = 5'd0;
        issue  = 1'b1;
        instr  = word;
        #1;
        // operands show the state from before this edge
        check_word("vj", ref_val[s1], vj);
        check_word("vk", ref_val[s2], vk);
        check_tag("qj", ref_tag[s1], qj);
        check_tag("qk", ref_tag[s2], qk);
        check_flag("rob_full", full, rob_full);
        if (!full) begin
            check_tag("issue_tag", next_tag, issue_tag);
            tag = next_tag;
            pend_tag.push_back(next_tag);
            pend_rd.push_back(writes ? d : 5'd0);
            if (writes && d != 5'd0) begin
                ref_tag[d] = next_tag;
            end
            next_tag = (next_tag == LAST_TAG) ? 5'd1 : next_tag + 5'd1;
        end
        @(posedge clk);
        #1;
        issue = 1'b0;
    endtask

    task automatic complete_op(input tomasulo_pkg::rob_tag_t tag,
                               input tomasulo_pkg::word_t value);
        cdb_valid      = 1'b1;
        cdb_tag        = tag;
        cdb_value      = value;
        done[tag]      = 1'b1;
        done_val[tag]  = value;
        @(posedge clk);
        #1;
        cdb_valid = 1'b0;
    endtask

    // waits until at most target entries remain in flight, returns the cycles taken
    task automatic wait_commits(input int target, output int cycles);
        cycles = 0;
        while (pend_tag.size() > target && cycles < 50) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pend_tag.size() > target) begin
            report_problem("reorder buffer did not retire its entries in time");
        end
    endtask

    // decode drives the read ports without an issue strobe
    task automatic read_check(input tomasulo_pkg::reg_idx_t r,
                              input tomasulo_pkg::word_t exp_val,
                              input tomasulo_pkg::rob_tag_t exp_tag);
        instr = encode(OP_REG, 5'd0, r, 5'd0);
        #1;
        check_word($sformatf("value of x%0d", r), exp_val, vj);
        check_tag($sformatf("tag of x%0d", r), exp_tag, qj);
        @(posedge clk);
        #1;
    endtask

    task automatic flush_rob();
        flush = 1'b1;
        for (int i = 0; i < 32; i++) begin
            ref_tag[i] = 5'd0;
            done[i]    = 1'b0;
        end
        pend_tag.delete();
        pend_rd.delete();
        next_tag = 5'd1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // the head entry retires at the edge after a negedge with commit_valid high
    always @(negedge clk) begin : commit_monitor
        tomasulo_pkg::rob_tag_t t;
        tomasulo_pkg::reg_idx_t r;
        if (!rst && commit_valid) begin
            if (pend_tag.size() == 0) begin
                report_problem("commit seen with no entry in flight");
            end else begin
                t = pend_tag.pop_front();
                r = pend_rd.pop_front();
                if (!done[t]) begin
                    report_problem("entry committed before its result arrived");
                end
                check_idx("commit_rd", r, commit_rd);
                check_word("commit_value", done_val[t], commit_value);
                if (r != 5'd0) begin
                    ref_val[r] = done_val[t];
                    if (ref_tag[r] == t) begin
                        ref_tag[r] = 5'd0;
                    end
                end
                done[t] = 1'b0;
            end
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_reset_state();
        tomasulo_pkg::rob_tag_t t;
        int                     cycles;
        start_test("reset_state");
        issue_op(encode(OP_REG, 5'd1, 5'd2, 5'd3), t);
        complete_op(t, $urandom());
        wait_commits(0, cycles);
        finish_test();
    endtask

    task automatic test_rename_dependency();
        tomasulo_pkg::rob_tag_t t1;
        tomasulo_pkg::rob_tag_t t2;
        int                     cycles;
        start_test("rename_dependency");
        issue_op(encode(OP_REG, 5'd5, 5'd1, 5'd2), t1);
        // the consumer sees the producer tag on both qj and qk
        issue_op(encode(OP_REG, 5'd6, 5'd5, 5'd5), t2);
        complete_op(t2, $urandom());
        complete_op(t1, $urandom());
        wait_commits(0, cycles);
        finish_test();
    endtask

    task automatic test_commit_order();
        tomasulo_pkg::rob_tag_t tags [4];
        tomasulo_pkg::word_t    vals [4];
        int                     cycles;
        start_test("commit_order");
        for (int i = 0; i < 4; i++) begin
            issue_op(encode(OP_REG, tomasulo_pkg::reg_idx_t'(10 + i), 5'd1, 5'd5), tags[i]);
            vals[i] = $urandom();
        end
        // youngest first, so nothing retires until the oldest is in
        for (int i = 3; i >= 0; i--) begin
            complete_op(tags[i], vals[i]);
        end
        wait_commits(0, cycles);
        if (cycles != 4) begin
            report_problem($sformatf("four ready entries took %0d cycles to commit", cycles));
        end
        for (int i = 0; i < 4; i++) begin
            read_check(tomasulo_pkg::reg_idx_t'(10 + i), vals[i], 5'd0);
        end
        finish_test();
    endtask

    task automatic test_x0_and_non_writing();
        tomasulo_pkg::rob_tag_t t [3];
        int                     cycles;
        start_test("x0_and_non_writing");
        issue_op(encode(OP_REG, 5'd0, 5'd1, 5'd2), t[0]);
        // bits 11:7 carry immediate data here and must not rename x9 or x12
        issue_op(encode(OP_STORE, 5'd9, 5'd3, 5'd4), t[1]);
        issue_op(encode(OP_BRANCH, 5'd12, 5'd5, 5'd6), t[2]);
        read_check(5'd9, ref_val[9], 5'd0);
        read_check(5'd12, ref_val[12], 5'd0);
        for (int i = 0; i < 3; i++) begin
            complete_op(t[i], $urandom() | 32'h1);
        end
        wait_commits(0, cycles);
        read_check(5'd0, 32'h0, 5'd0);
        read_check(5'd9, ref_val[9], 5'd0);
        read_check(5'd12, ref_val[12], 5'd0);
        finish_test();
    endtask

    task automatic test_write_after_write();
        tomasulo_pkg::rob_tag_t ta;
        tomasulo_pkg::rob_tag_t tb;
        tomasulo_pkg::word_t    va;
        tomasulo_pkg::word_t    vb;
        int                     cycles;
        start_test("write_after_write");
        va = $urandom();
        vb = $urandom();
        issue_op(encode(OP_REG, 5'd20, 5'd1, 5'd2), ta);
        issue_op(encode(OP_REG, 5'd20, 5'd3, 5'd4), tb);
        complete_op(ta, va);
        wait_commits(1, cycles);
        // older commit writes its value but leaves the younger producer in place
        read_check(5'd20, va, tb);
        complete_op(tb, vb);
        wait_commits(0, cycles);
        read_check(5'd20, vb, 5'd0);
        finish_test();
    endtask

    task automatic test_full_and_flush();
        tomasulo_pkg::rob_tag_t t;
        int                     cycles;
        start_test("full_and_flush");
        for (int i = 1; i <= ROB_DEPTH; i++) begin
            issue_op(encode(OP_REG, tomasulo_pkg::reg_idx_t'(i), 5'd0, 5'd0), t);
        end
        check_flag("rob_full after eight issues", 1'b1, rob_full);
        // dropped issue, so x9 must stay without a producer
        issue_op(encode(OP_REG, 5'd9, 5'd0, 5'd0), t);
        read_check(5'd9, ref_val[9], 5'd0);
        flush_rob();
        check_flag("rob_full after flush", 1'b0, rob_full);
        for (int i = 1; i <= 9; i++) begin
            read_check(tomasulo_pkg::reg_idx_t'(i), ref_val[i], 5'd0);
        end
        issue_op(encode(OP_REG, 5'd7, 5'd1, 5'd6), t);
        complete_op(t, $urandom());
        wait_commits(0, cycles);
        finish_test();
    endtask

    // the tests take about 80 cycles and 2000 leaves a wide margin
    initial begin
        repeat (2000) @(posedge clk);
        $display("watchdog: simulation did not finish within 2000 cycles");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(14));
        rst       = 1'b1;
        flush     = 1'b0;
        issue     = 1'b0;
        instr     = 32'h0;
        cdb_valid = 1'b0;
        cdb_tag   = 5'd0;
        cdb_value = 32'h0;
        for (int i = 0; i < 32; i++) begin
            ref_val[i] = 32'h0;
            ref_tag[i] = 5'd0;
            done[i]    = 1'b0;
        end
        next_tag     = 5'd1;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_rename_dependency();
        test_commit_order();
        test_x0_and_non_writing();
        test_write_after_write();
        test_full_and_flush();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : rename_core_tb

`default_nettype wire

// File: verilog.f
common/tomasulo_pkg.sv
register_status/register_status_file.sv
reorder_buffer/reorder_buffer.sv
design/dispatch_unit.sv
design/rename_core.sv
verification/rename_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = rename_core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
